/* common/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and PC width
`define XLEN        32
`define INSTR_W     32

// Register file geometry
`define REG_ADDR_W  5
`define REG_COUNT   32

// Debug write-back enable width
`define WEN_W       4

// Three-register major opcodes, instr[31:15]
`define OP3R_ADD_W  17'h00020
`define OP3R_SUB_W  17'h00022
`define OP3R_SLT    17'h00024
`define OP3R_SLTU   17'h00025
`define OP3R_AND    17'h00029
`define OP3R_OR     17'h0002a
`define OP3R_XOR    17'h0002b

// addi.w opcode, instr[31:22]
`define OP_ADDI_W   10'h00a

// lu12i.w opcode, instr[31:25]
`define OP_LU12I_W  7'h0a

`endif

/* common/core_pkg.sv */
`default_nettype none

`include "core_defines.svh"

package core_pkg;

    // Operation selected by the decoder for the execute stage
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_SLT  = 3'd2,
        ALU_SLTU = 3'd3,
        ALU_AND  = 3'd4,
        ALU_OR   = 3'd5,
        ALU_XOR  = 3'd6,
        ALU_LUI  = 3'd7
    } alu_op_e;

    // One instruction in flight between stages
    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        alu_op_e                alu_op;
        logic [`REG_ADDR_W-1:0] rd;
        // Clear for r0 and for unknown opcodes
        logic                   wen;
        // Holds the ALU result once past execute
        logic [`XLEN-1:0]       src_a;
        // Register or immediate, already chosen
        logic [`XLEN-1:0]       src_b;
    } decoded_t;

endpackage

`default_nettype wire

/* decode/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module regfile (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   we_i,
    input  wire logic [`REG_ADDR_W-1:0] waddr_i,
    input  wire logic [`XLEN-1:0]       wdata_i,
    input  wire logic [`REG_ADDR_W-1:0] raddr_a_i,
    input  wire logic [`REG_ADDR_W-1:0] raddr_b_i,
    output logic [`XLEN-1:0]            rdata_a_o,
    output logic [`XLEN-1:0]            rdata_b_o
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // Architectural state starts from zero
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous read, r0 hardwired
    always_comb begin
        if (raddr_a_i == '0) begin
            rdata_a_o = '0;
        end else begin
            rdata_a_o = regs[raddr_a_i];
        end
    end

    always_comb begin
        if (raddr_b_i == '0) begin
            rdata_b_o = '0;
        end else begin
            rdata_b_o = regs[raddr_b_i];
        end
    end

endmodule

`default_nettype wire

/* decode/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module instr_decoder (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   instr_valid_i,
    input  wire logic [`INSTR_W-1:0]    instr_i,
    input  wire logic [`XLEN-1:0]       pc_i,
    output logic [`REG_ADDR_W-1:0]      rf_raddr_a_o,
    output logic [`REG_ADDR_W-1:0]      rf_raddr_b_o,
    input  wire logic [`XLEN-1:0]       rf_rdata_a_i,
    input  wire logic [`XLEN-1:0]       rf_rdata_b_i,
    input  wire logic                   fwd_ex_wen_i,
    input  wire logic [`REG_ADDR_W-1:0] fwd_ex_rd_i,
    input  wire logic [`XLEN-1:0]       fwd_ex_data_i,
    input  wire logic                   fwd_wb_wen_i,
    input  wire logic [`REG_ADDR_W-1:0] fwd_wb_rd_i,
    input  wire logic [`XLEN-1:0]       fwd_wb_data_i,
    output core_pkg::decoded_t          ex_instr_o
);

    logic [`REG_ADDR_W-1:0] rd;
    logic                   known;
    logic                   use_imm;
    logic [`XLEN-1:0]       imm;
    core_pkg::alu_op_e      alu_op;
    core_pkg::decoded_t     dec;
    core_pkg::decoded_t     ex_q;

    // Newest producer wins: execute, then result, then register file
    function automatic logic [`XLEN-1:0] fwd_operand(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`XLEN-1:0]       rf_data
    );
        if (fwd_ex_wen_i && fwd_ex_rd_i == addr) begin
            return fwd_ex_data_i;
        end else if (fwd_wb_wen_i && fwd_wb_rd_i == addr) begin
            return fwd_wb_data_i;
        end
        return rf_data;
    endfunction

    assign rd           = instr_i[4:0];
    assign rf_raddr_a_o = instr_i[9:5];
    assign rf_raddr_b_o = instr_i[14:10];

    always_comb begin
        known   = 1'b1;
        use_imm = 1'b0;
        imm     = '0;
        alu_op  = core_pkg::ALU_ADD;
        case (instr_i[31:15])
            `OP3R_ADD_W: alu_op = core_pkg::ALU_ADD;
            `OP3R_SUB_W: alu_op = core_pkg::ALU_SUB;
            `OP3R_SLT:   alu_op = core_pkg::ALU_SLT;
            `OP3R_SLTU:  alu_op = core_pkg::ALU_SLTU;
            `OP3R_AND:   alu_op = core_pkg::ALU_AND;
            `OP3R_OR:    alu_op = core_pkg::ALU_OR;
            `OP3R_XOR:   alu_op = core_pkg::ALU_XOR;
            default: begin
                if (instr_i[31:22] == `OP_ADDI_W) begin
                    // si12 sign-extended
                    use_imm = 1'b1;
                    imm     = {{(`XLEN-12){instr_i[21]}}, instr_i[21:10]};
                end else if (instr_i[31:25] == `OP_LU12I_W) begin
                    alu_op  = core_pkg::ALU_LUI;
                    use_imm = 1'b1;
                    imm     = {instr_i[24:5], 12'b0};
                end else begin
                    known = 1'b0;
                end
            end
        endcase
    end

    always_comb begin
        dec.valid  = instr_valid_i;
        dec.pc     = pc_i;
        dec.alu_op = alu_op;
        dec.rd     = rd;
        // r0 writes are dropped here and nowhere else
        dec.wen    = known && (rd != '0);
        dec.src_a  = fwd_operand(rf_raddr_a_o, rf_rdata_a_i);
        dec.src_b  = use_imm ? imm : fwd_operand(rf_raddr_b_o, rf_rdata_b_i);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_q <= '0;
        end else begin
            ex_q <= dec;
        end
    end

    assign ex_instr_o = ex_q;

endmodule

`default_nettype wire

/* execute/alu_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module alu_stage (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire core_pkg::decoded_t ex_instr_i,
    output core_pkg::decoded_t      wb_instr_o,
    output logic                    fwd_ex_wen_o,
    output logic [`REG_ADDR_W-1:0]  fwd_ex_rd_o,
    output logic [`XLEN-1:0]        fwd_ex_data_o
);

    logic [`XLEN-1:0]   src_a;
    logic [`XLEN-1:0]   src_b;
    logic [`XLEN-1:0]   result;
    logic               lt_signed;
    logic               lt_unsigned;
    core_pkg::decoded_t wb_d;
    core_pkg::decoded_t wb_q;

    assign src_a = ex_instr_i.src_a;
    assign src_b = ex_instr_i.src_b;

    assign lt_signed   = $signed(src_a) < $signed(src_b);
    assign lt_unsigned = src_a < src_b;

    always_comb begin
        case (ex_instr_i.alu_op)
            core_pkg::ALU_ADD:  result = src_a + src_b;
            core_pkg::ALU_SUB:  result = src_a - src_b;
            core_pkg::ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lt_signed};
            core_pkg::ALU_SLTU: result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            core_pkg::ALU_AND:  result = src_a & src_b;
            core_pkg::ALU_OR:   result = src_a | src_b;
            core_pkg::ALU_XOR:  result = src_a ^ src_b;
            // Immediate already shifted by the decoder
            core_pkg::ALU_LUI:  result = src_b;
            default:            result = '0;
        endcase
    end

    // Result seen by the instruction now in decode
    assign fwd_ex_wen_o  = ex_instr_i.valid && ex_instr_i.wen;
    assign fwd_ex_rd_o   = ex_instr_i.rd;
    assign fwd_ex_data_o = result;

    // src_a carries the result from here on
    always_comb begin
        wb_d       = ex_instr_i;
        wb_d.src_a = result;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_d;
        end
    end

    assign wb_instr_o = wb_q;

endmodule

`default_nettype wire

/* logic/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module result_stage (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire core_pkg::decoded_t wb_instr_i,
    output logic                    rf_we_o,
    output logic [`REG_ADDR_W-1:0]  rf_waddr_o,
    output logic [`XLEN-1:0]        rf_wdata_o,
    output logic                    fwd_wb_wen_o,
    output logic [`REG_ADDR_W-1:0]  fwd_wb_rd_o,
    output logic [`XLEN-1:0]        fwd_wb_data_o,
    output logic [`XLEN-1:0]        debug_wb_pc_o,
    output logic [`WEN_W-1:0]       debug_wb_rf_wen_o,
    output logic [`REG_ADDR_W-1:0]  debug_wb_rf_wnum_o,
    output logic [`XLEN-1:0]        debug_wb_rf_wdata_o
);

    logic commit_we;

    assign commit_we = wb_instr_i.valid && wb_instr_i.wen;

    // Register file write lands on the same edge as the debug update
    assign rf_we_o    = commit_we;
    assign rf_waddr_o = wb_instr_i.rd;
    assign rf_wdata_o = wb_instr_i.src_a;

    // Covers the gap until the write reaches the register file
    assign fwd_wb_wen_o  = commit_we;
    assign fwd_wb_rd_o   = wb_instr_i.rd;
    assign fwd_wb_data_o = wb_instr_i.src_a;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            debug_wb_pc_o       <= '0;
            debug_wb_rf_wen_o   <= '0;
            debug_wb_rf_wnum_o  <= '0;
            debug_wb_rf_wdata_o <= '0;
        end else begin
            debug_wb_pc_o       <= wb_instr_i.pc;
            debug_wb_rf_wen_o   <= {{(`WEN_W-1){1'b0}}, commit_we};
            debug_wb_rf_wnum_o  <= wb_instr_i.rd;
            debug_wb_rf_wdata_o <= wb_instr_i.src_a;
        end
    end

endmodule

`default_nettype wire

/* logic/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_top (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire logic                instr_valid_i,
    input  wire logic [`INSTR_W-1:0] instr_i,
    input  wire logic [`XLEN-1:0]    pc_i,
    output logic [`XLEN-1:0]         debug_wb_pc_o,
    output logic [`WEN_W-1:0]        debug_wb_rf_wen_o,
    output logic [`REG_ADDR_W-1:0]   debug_wb_rf_wnum_o,
    output logic [`XLEN-1:0]         debug_wb_rf_wdata_o
);

    // Decode <-> register file
    logic [`REG_ADDR_W-1:0] rf_raddr_a;
    logic [`REG_ADDR_W-1:0] rf_raddr_b;
    logic [`XLEN-1:0]       rf_rdata_a;
    logic [`XLEN-1:0]       rf_rdata_b;

    // Result stage -> register file
    logic                   rf_we;
    logic [`REG_ADDR_W-1:0] rf_waddr;
    logic [`XLEN-1:0]       rf_wdata;

    // Forwarding back into decode
    logic                   fwd_ex_wen;
    logic [`REG_ADDR_W-1:0] fwd_ex_rd;
    logic [`XLEN-1:0]       fwd_ex_data;
    logic                   fwd_wb_wen;
    logic [`REG_ADDR_W-1:0] fwd_wb_rd;
    logic [`XLEN-1:0]       fwd_wb_data;

    // Stage registers
    core_pkg::decoded_t     ex_instr;
    core_pkg::decoded_t     wb_instr;

    instr_decoder i_instr_decoder (
        .clk          (clk),
        .reset_i      (reset_i),
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_rdata_a_i (rf_rdata_a),
        .rf_rdata_b_i (rf_rdata_b),
        .fwd_ex_wen_i (fwd_ex_wen),
        .fwd_ex_rd_i  (fwd_ex_rd),
        .fwd_ex_data_i(fwd_ex_data),
        .fwd_wb_wen_i (fwd_wb_wen),
        .fwd_wb_rd_i  (fwd_wb_rd),
        .fwd_wb_data_i(fwd_wb_data),
        .ex_instr_o   (ex_instr)
    );

    regfile i_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .raddr_a_i(rf_raddr_a),
        .raddr_b_i(rf_raddr_b),
        .rdata_a_o(rf_rdata_a),
        .rdata_b_o(rf_rdata_b)
    );

    alu_stage i_alu_stage (
        .clk          (clk),
        .reset_i      (reset_i),
        .ex_instr_i   (ex_instr),
        .wb_instr_o   (wb_instr),
        .fwd_ex_wen_o (fwd_ex_wen),
        .fwd_ex_rd_o  (fwd_ex_rd),
        .fwd_ex_data_o(fwd_ex_data)
    );

    result_stage i_result_stage (
        .clk                (clk),
        .reset_i            (reset_i),
        .wb_instr_i         (wb_instr),
        .rf_we_o            (rf_we),
        .rf_waddr_o         (rf_waddr),
        .rf_wdata_o         (rf_wdata),
        .fwd_wb_wen_o       (fwd_wb_wen),
        .fwd_wb_rd_o        (fwd_wb_rd),
        .fwd_wb_data_o      (fwd_wb_data),
        .debug_wb_pc_o      (debug_wb_pc_o),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

endmodule

`default_nettype wire

/* testbench/tb_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;

    // LoongArch32 opcode fields
    localparam logic [16:0] OPC_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_SLT     = 17'h00024;
    localparam logic [16:0] OPC_SLTU    = 17'h00025;
    localparam logic [16:0] OPC_AND     = 17'h00029;
    localparam logic [16:0] OPC_OR      = 17'h0002a;
    localparam logic [16:0] OPC_XOR     = 17'h0002b;
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;

    logic        clk;
    logic        reset_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic [31:0] debug_wb_pc_o;
    logic [3:0]  debug_wb_rf_wen_o;
    logic [4:0]  debug_wb_rf_wnum_o;
    logic [31:0] debug_wb_rf_wdata_o;

    // One slot per cycle with stimulus and the expected write-back
    logic        tbl_valid[$];
    logic [31:0] tbl_instr[$];
    logic [31:0] tbl_pc[$];
    logic [3:0]  tbl_wen[$];
    logic [4:0]  tbl_wnum[$];
    logic [31:0] tbl_wdata[$];

    integer      seed;
    logic [31:0] next_pc;
    int          errors;
    int          checks;
    bit          timed_out;

    core_top i_core_top (
        .clk                (clk),
        .reset_i            (reset_i),
        .instr_valid_i      (instr_valid_i),
        .instr_i            (instr_i),
        .pc_i               (pc_i),
        .debug_wb_pc_o      (debug_wb_pc_o),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] rrr_word(
        input logic [16:0] op,
        input logic [4:0]  rd,
        input logic [4:0]  rj,
        input logic [4:0]  rk
    );
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] addi_word(
        input logic [4:0]  rd,
        input logic [4:0]  rj,
        input logic [11:0] si12
    );
        return {OPC_ADDI_W, si12, rj, rd};
    endfunction

    function automatic logic [31:0] lu12i_word(
        input logic [4:0]  rd,
        input logic [19:0] si20
    );
        return {OPC_LU12I_W, si20, rd};
    endfunction

    task automatic push_instr(
        input logic [31:0] instr,
        input logic        wen,
        input logic [4:0]  wnum,
        input logic [31:0] wdata
    );
        tbl_valid.push_back(1'b1);
        tbl_instr.push_back(instr);
        tbl_pc.push_back(next_pc);
        tbl_wen.push_back({3'b000, wen});
        tbl_wnum.push_back(wnum);
        tbl_wdata.push_back(wdata);
        next_pc = next_pc + 32'd4;
    endtask

    // Idle slot with random garbage on instr_i
    task automatic push_idle();
        logic [31:0] word;
        word = $random(seed);
        tbl_valid.push_back(1'b0);
        tbl_instr.push_back(word);
        tbl_pc.push_back(next_pc);
        tbl_wen.push_back(4'd0);
        tbl_wnum.push_back(5'd0);
        tbl_wdata.push_back(32'd0);
    endtask

    task automatic build_program();
        repeat (4) push_idle();
        // Constants
        push_instr(lu12i_word(5'd1, 20'h12345), 1'b1, 5'd1, 32'h12345000);
        push_instr(addi_word(5'd1, 5'd1, 12'h678), 1'b1, 5'd1, 32'h12345678);
        push_instr(addi_word(5'd2, 5'd0, 12'hfff), 1'b1, 5'd2, 32'hffffffff);
        push_instr(addi_word(5'd3, 5'd0, 12'h005), 1'b1, 5'd3, 32'h00000005);
        push_instr(lu12i_word(5'd21, 20'h80000), 1'b1, 5'd21, 32'h80000000);
        // Three-register operations
        push_instr(rrr_word(OPC_ADD_W, 5'd4, 5'd1, 5'd3), 1'b1, 5'd4, 32'h1234567d);
        push_instr(rrr_word(OPC_SUB_W, 5'd5, 5'd3, 5'd2), 1'b1, 5'd5, 32'h00000006);
        push_instr(rrr_word(OPC_SLT, 5'd6, 5'd2, 5'd3), 1'b1, 5'd6, 32'h00000001);
        push_instr(rrr_word(OPC_SLTU, 5'd7, 5'd2, 5'd3), 1'b1, 5'd7, 32'h00000000);
        push_instr(rrr_word(OPC_SLTU, 5'd19, 5'd3, 5'd2), 1'b1, 5'd19, 32'h00000001);
        push_instr(rrr_word(OPC_SLT, 5'd20, 5'd3, 5'd2), 1'b1, 5'd20, 32'h00000000);
        push_instr(rrr_word(OPC_AND, 5'd8, 5'd5, 5'd3), 1'b1, 5'd8, 32'h00000004);
        push_instr(rrr_word(OPC_OR, 5'd9, 5'd3, 5'd5), 1'b1, 5'd9, 32'h00000007);
        push_instr(rrr_word(OPC_XOR, 5'd10, 5'd1, 5'd2), 1'b1, 5'd10, 32'hedcba987);
        push_instr(addi_word(5'd11, 5'd2, 12'h800), 1'b1, 5'd11, 32'hfffff7ff);
        // Back-to-back dependencies
        push_instr(addi_word(5'd12, 5'd0, 12'h00a), 1'b1, 5'd12, 32'd10);
        push_instr(rrr_word(OPC_ADD_W, 5'd13, 5'd12, 5'd12), 1'b1, 5'd13, 32'd20);
        push_instr(rrr_word(OPC_SUB_W, 5'd14, 5'd13, 5'd12), 1'b1, 5'd14, 32'd10);
        push_instr(rrr_word(OPC_ADD_W, 5'd12, 5'd12, 5'd14), 1'b1, 5'd12, 32'd20);
        push_instr(rrr_word(OPC_ADD_W, 5'd15, 5'd12, 5'd13), 1'b1, 5'd15, 32'd40);
        push_instr(addi_word(5'd12, 5'd12, 12'h001), 1'b1, 5'd12, 32'd21);
        push_instr(addi_word(5'd12, 5'd12, 12'h001), 1'b1, 5'd12, 32'd22);
        // r12 in both later stages and the newest value wins
        push_instr(addi_word(5'd16, 5'd12, 12'h000), 1'b1, 5'd16, 32'd22);
        // r0 stays zero and an unknown opcode writes nothing
        push_instr(addi_word(5'd0, 5'd3, 12'h007), 1'b0, 5'd0, 32'd0);
        push_instr(rrr_word(OPC_ADD_W, 5'd17, 5'd0, 5'd3), 1'b1, 5'd17, 32'd5);
        push_instr(rrr_word(17'h1ffff, 5'd31, 5'd3, 5'd3), 1'b0, 5'd31, 32'd0);
        push_instr(rrr_word(OPC_OR, 5'd18, 5'd31, 5'd3), 1'b1, 5'd18, 32'd5);
        repeat (3) push_idle();
        // Drain slots that are never checked
        repeat (2) push_idle();
    endtask

    task automatic check_entry(input int idx);
        checks++;
        if (debug_wb_rf_wen_o !== tbl_wen[idx]) begin
            $display("[ERROR] %0t: slot %0d wen is %0h, expected %0h",
                     $time, idx, debug_wb_rf_wen_o, tbl_wen[idx]);
            errors++;
        end
        if (tbl_valid[idx]) begin
            if (debug_wb_pc_o !== tbl_pc[idx]) begin
                $display("[ERROR] %0t: slot %0d pc is %h, expected %h",
                         $time, idx, debug_wb_pc_o, tbl_pc[idx]);
                errors++;
            end
            if (tbl_wen[idx] != 4'd0) begin
                if (debug_wb_rf_wnum_o !== tbl_wnum[idx]) begin
                    $display("[ERROR] %0t: slot %0d wnum is %0d, expected %0d",
                             $time, idx, debug_wb_rf_wnum_o, tbl_wnum[idx]);
                    errors++;
                end
                if (debug_wb_rf_wdata_o !== tbl_wdata[idx]) begin
                    $display("[ERROR] %0t: slot %0d wdata is %h, expected %h",
                             $time, idx, debug_wb_rf_wdata_o, tbl_wdata[idx]);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        int waited;
        bit cleared;
        seed          = 32'hca69;
        clk           = 1'b0;
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = 32'd0;
        pc_i          = 32'd0;
        errors        = 0;
        checks        = 0;
        timed_out     = 1'b0;
        next_pc       = 32'h1c000000;
        build_program();

        repeat (8) @(negedge clk);
        reset_i = 1'b0;

        // Debug outputs must read zero once out of reset
        waited  = 0;
        cleared = 1'b0;
        while (!cleared && waited < 20) begin
            @(negedge clk);
            waited++;
            cleared = (debug_wb_rf_wen_o == 4'd0) && (debug_wb_pc_o == 32'd0) &&
                      (debug_wb_rf_wnum_o == 5'd0) && (debug_wb_rf_wdata_o == 32'd0);
        end

        if (!cleared) begin
            $display("Timeout: debug outputs still not zero 20 cycles after reset");
            timed_out = 1'b1;
        end else begin
            // Slot n shows up on the debug port at the third falling edge
            for (int n = 0; n < tbl_valid.size(); n++) begin
                instr_valid_i = tbl_valid[n];
                instr_i       = tbl_instr[n];
                pc_i          = tbl_pc[n];
                @(negedge clk);
                if (n >= 2) begin
                    check_entry(n - 2);
                end
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (timed_out || errors != 0) begin
            $display(">>> FAIL");
        end else begin
            $display(">>> PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/core_pkg.sv
decode/regfile.sv
decode/instr_decoder.sv
execute/alu_stage.sv
logic/result_stage.sv
logic/core_top.sv
testbench/tb_core_top.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f verilog.f \
    --top-module tb_core_top \
    -Mdir obj_dir \
    -o tb_core_top

./obj_dir/tb_core_top | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
